// ==== logic/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] irq_vec_t;

  // addr[15:12] picks the region, addr[11:0] is the register offset
  typedef logic [3:0] region_t;
  typedef logic [11:0] offs_t;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
  } nmi_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } nmi_rsp_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    offs_t paddr;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    data_t prdata;
  } apb_rsp_t;

  // address map
  localparam region_t REGION_NATV = 4'h0;
  localparam region_t REGION_APB = 4'h1;

  localparam offs_t SYS_CTRL = 12'h000;
  localparam offs_t SYS_NOUT = 12'h004;
  localparam offs_t SYS_SWIRQ = 12'h008;

  localparam offs_t APB_OUT = 12'h000;
  localparam offs_t TMR_CMP = 12'h004;
  localparam offs_t TMR_CNT = 12'h008;
  localparam offs_t TMR_CTRL = 12'h00C;

  // interrupt vector bit positions
  localparam int unsigned IRQ_TMR = 0;
  localparam int unsigned IRQ_SW = 1;
  localparam int unsigned IRQ_EXT = 2;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } bridge_state_t;

endpackage

`default_nettype wire

// ==== logic/nmi_bus.sv ====
`default_nettype none

module nmi_bus (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::nmi_req_t mst_req_i,
  output soc_pkg::nmi_rsp_t mst_rsp_o,
  output soc_pkg::nmi_req_t natv_req_o,
  input  soc_pkg::nmi_rsp_t natv_rsp_i,
  output soc_pkg::nmi_req_t apb_req_o,
  input  soc_pkg::nmi_rsp_t apb_rsp_i
);

  soc_pkg::region_t region;
  logic             sel_natv;
  logic             sel_apb;
  logic             err_valid;
  logic             err_rdy_q;

  // region decode, the master holds addr until ready
  assign region   = mst_req_i.addr[15:12];
  assign sel_natv = (region == soc_pkg::REGION_NATV);
  assign sel_apb  = (region == soc_pkg::REGION_APB);

  assign err_valid = mst_req_i.valid & ~sel_natv & ~sel_apb;

  // forward to one target only
  always_comb begin
    natv_req_o       = mst_req_i;
    natv_req_o.valid = mst_req_i.valid & sel_natv;
    apb_req_o        = mst_req_i;
    apb_req_o.valid  = mst_req_i.valid & sel_apb;
  end

  // unmapped region answers after one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_rdy_q <= 1'b0;
    end else begin
      err_rdy_q <= err_valid & ~err_rdy_q;
    end
  end

  // response back to the master
  always_comb begin
    if (sel_natv) begin
      mst_rsp_o = natv_rsp_i;
    end else if (sel_apb) begin
      mst_rsp_o = apb_rsp_i;
    end else begin
      mst_rsp_o.ready = err_rdy_q;
      mst_rsp_o.rdata = '0;
    end
  end

  // a pending request must not move under the target
  a_addr_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mst_req_i.valid && !mst_rsp_o.ready) |=> $stable(mst_req_i.addr)
  ) else $error("nmi addr changed while request was waiting");

endmodule

`default_nettype wire

// ==== logic/sysctrl_regs.sv ====
`default_nettype none

module sysctrl_regs #(
  parameter int unsigned PIN_W = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::nmi_req_t req_i,
  output soc_pkg::nmi_rsp_t rsp_o,
  output logic              pin_sel_o,
  output logic [PIN_W-1:0]  natv_out_o,
  output logic              sw_irq_o
);

  soc_pkg::offs_t   offs;
  logic             rdy_q;
  logic             wr_en;
  logic             pin_sel_q;
  logic [PIN_W-1:0] nout_q;
  logic             swirq_q;

  assign offs = req_i.addr[11:0];

  // one ready pulse per request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= req_i.valid & ~rdy_q;
    end
  end

  // write lands on the completing edge
  assign wr_en = req_i.valid & req_i.we & rdy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pin_sel_q <= 1'b0;
      nout_q    <= '0;
      swirq_q   <= 1'b0;
    end else if (wr_en) begin
      case (offs)
        soc_pkg::SYS_CTRL:  pin_sel_q <= req_i.wdata[0];
        soc_pkg::SYS_NOUT:  nout_q <= req_i.wdata[PIN_W-1:0];
        soc_pkg::SYS_SWIRQ: swirq_q <= req_i.wdata[0];
        default: ;
      endcase
    end
  end

  // read mux with zeros in the upper bits
  always_comb begin
    rsp_o.ready = rdy_q;
    rsp_o.rdata = '0;
    case (offs)
      soc_pkg::SYS_CTRL:  rsp_o.rdata[0] = pin_sel_q;
      soc_pkg::SYS_NOUT:  rsp_o.rdata[PIN_W-1:0] = nout_q;
      soc_pkg::SYS_SWIRQ: rsp_o.rdata[0] = swirq_q;
      default: ;
    endcase
  end

  assign pin_sel_o  = pin_sel_q;
  assign natv_out_o = nout_q;
  assign sw_irq_o   = swirq_q;

  a_ready_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.ready |-> req_i.valid
  ) else $error("native ready without a pending request");

endmodule

`default_nettype wire

// ==== logic/nmi_apb_bridge.sv ====
`default_nettype none

module nmi_apb_bridge (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::nmi_req_t req_i,
  output soc_pkg::nmi_rsp_t rsp_o,
  output soc_pkg::apb_req_t apb_req_o,
  input  soc_pkg::apb_rsp_t apb_rsp_i
);

  soc_pkg::bridge_state_t state_q;
  soc_pkg::bridge_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_pkg::IDLE: begin
        if (req_i.valid) begin
          state_d = soc_pkg::SETUP;
        end
      end
      soc_pkg::SETUP: state_d = soc_pkg::ACCESS;
      soc_pkg::ACCESS: begin
        // wait states are allowed here
        if (apb_rsp_i.pready) begin
          state_d = soc_pkg::IDLE;
        end
      end
      default: state_d = soc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= soc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // address and data come straight from the held nmi request
  always_comb begin
    apb_req_o.psel    = (state_q != soc_pkg::IDLE);
    apb_req_o.penable = (state_q == soc_pkg::ACCESS);
    apb_req_o.pwrite  = req_i.we;
    apb_req_o.paddr   = req_i.addr[11:0];
    apb_req_o.pwdata  = req_i.wdata;
  end

  assign rsp_o.ready = (state_q == soc_pkg::ACCESS) & apb_rsp_i.pready;
  assign rsp_o.rdata = apb_rsp_i.prdata;

  a_psel_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    apb_req_o.psel |-> req_i.valid
  ) else $error("nmi request dropped during apb transfer");

endmodule

`default_nettype wire

// ==== logic/apb_tmr_gpio.sv ====
`default_nettype none

module apb_tmr_gpio #(
  parameter int unsigned PIN_W = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::apb_req_t apb_req_i,
  output soc_pkg::apb_rsp_t apb_rsp_o,
  output logic [PIN_W-1:0]  apb_out_o,
  output logic              tmr_irq_o
);

  logic             wr_en;
  logic             match;
  logic [PIN_W-1:0] out_q;
  soc_pkg::data_t   cmp_q;
  soc_pkg::data_t   cnt_q;
  logic             en_q;
  logic             pend_q;

  // writes happen in the access phase
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  assign match = en_q & (cnt_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      cmp_q <= '0;
      en_q  <= 1'b0;
    end else if (wr_en) begin
      case (apb_req_i.paddr)
        soc_pkg::APB_OUT:  out_q <= apb_req_i.pwdata[PIN_W-1:0];
        soc_pkg::TMR_CMP:  cmp_q <= apb_req_i.pwdata;
        soc_pkg::TMR_CTRL: en_q <= apb_req_i.pwdata[0];
        default: ;
      endcase
    end
  end

  // free running compare counter, wraps on match
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (match) begin
      cnt_q <= '0;
    end else if (en_q) begin
      cnt_q <= cnt_q + 32'd1;
    end
  end

  // match beats a write-1 clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else if (match) begin
      pend_q <= 1'b1;
    end else if (wr_en && apb_req_i.paddr == soc_pkg::TMR_CTRL && apb_req_i.pwdata[1]) begin
      pend_q <= 1'b0;
    end
  end

  always_comb begin
    apb_rsp_o.pready = 1'b1;
    apb_rsp_o.prdata = '0;
    case (apb_req_i.paddr)
      soc_pkg::APB_OUT:  apb_rsp_o.prdata[PIN_W-1:0] = out_q;
      soc_pkg::TMR_CMP:  apb_rsp_o.prdata = cmp_q;
      soc_pkg::TMR_CNT:  apb_rsp_o.prdata = cnt_q;
      soc_pkg::TMR_CTRL: apb_rsp_o.prdata[1:0] = {pend_q, en_q};
      default: ;
    endcase
  end

  assign apb_out_o = out_q;
  assign tmr_irq_o = pend_q;

endmodule

`default_nettype wire

// ==== logic/mini_soc.sv ====
`default_nettype none

module mini_soc #(
  parameter int unsigned PIN_W = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::nmi_req_t nmi_req_i,
  output soc_pkg::nmi_rsp_t nmi_rsp_o,
  input  logic              ext_irq_i,
  output logic [PIN_W-1:0]  pins_o,
  output soc_pkg::irq_vec_t irq_o
);

  soc_pkg::nmi_req_t natv_req;
  soc_pkg::nmi_rsp_t natv_rsp;
  soc_pkg::nmi_req_t apb_nmi_req;
  soc_pkg::nmi_rsp_t apb_nmi_rsp;
  soc_pkg::apb_req_t apb_req;
  soc_pkg::apb_rsp_t apb_rsp;

  logic             pin_sel;
  logic             sw_irq;
  logic             tmr_irq;
  logic [PIN_W-1:0] natv_out;
  logic [PIN_W-1:0] apb_out;

  // native or apb wrapper drives the pins
  assign pins_o = pin_sel ? apb_out : natv_out;

  always_comb begin
    irq_o = '0;
    irq_o[soc_pkg::IRQ_TMR] = tmr_irq;
    irq_o[soc_pkg::IRQ_SW]  = sw_irq;
    irq_o[soc_pkg::IRQ_EXT] = ext_irq_i;
  end

  nmi_bus u_bus (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mst_req_i (nmi_req_i),
    .mst_rsp_o (nmi_rsp_o),
    .natv_req_o(natv_req),
    .natv_rsp_i(natv_rsp),
    .apb_req_o (apb_nmi_req),
    .apb_rsp_i (apb_nmi_rsp)
  );

  sysctrl_regs #(
    .PIN_W(PIN_W)
  ) u_sysctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (natv_req),
    .rsp_o     (natv_rsp),
    .pin_sel_o (pin_sel),
    .natv_out_o(natv_out),
    .sw_irq_o  (sw_irq)
  );

  nmi_apb_bridge u_bridge (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (apb_nmi_req),
    .rsp_o    (apb_nmi_rsp),
    .apb_req_o(apb_req),
    .apb_rsp_i(apb_rsp)
  );

  apb_tmr_gpio #(
    .PIN_W(PIN_W)
  ) u_tmr_gpio (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .apb_req_i(apb_req),
    .apb_rsp_o(apb_rsp),
    .apb_out_o(apb_out),
    .tmr_irq_o(tmr_irq)
  );

endmodule

`default_nettype wire

// ==== test/tb_mini_soc.sv ====
`default_nettype none

module tb_mini_soc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned PIN_W = 16;
  localparam int unsigned N_RAND = 80;
  localparam int unsigned N_MUX = 12;
  localparam int unsigned N_IRQ = 12;
  // upper bound on bus accesses over the whole run
  localparam int unsigned N_ACCESS = N_RAND + 4 * N_MUX + N_IRQ + 16;
  localparam soc_pkg::data_t PIN_MASK = (32'd1 << PIN_W) - 32'd1;

  logic              clk_i;
  logic              rst_n_i;
  soc_pkg::nmi_req_t nmi_req;
  soc_pkg::nmi_rsp_t nmi_rsp;
  logic              ext_irq;
  logic [PIN_W-1:0]  pins;
  soc_pkg::irq_vec_t irq;

  // shadow copies of the writable registers
  soc_pkg::data_t m_nout;
  soc_pkg::data_t m_apb_out;
  soc_pkg::data_t m_cmp;
  logic           m_pin_sel;
  logic           m_sw_irq;

  int unsigned errors;
  logic [31:0] seed;

  mini_soc #(
    .PIN_W(PIN_W)
  ) dut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .nmi_req_i(nmi_req),
    .nmi_rsp_o(nmi_rsp),
    .ext_irq_i(ext_irq),
    .pins_o   (pins),
    .irq_o    (irq)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // halves swapped so low bits do not just alternate
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};
  endfunction

  function automatic soc_pkg::addr_t natv_addr(input soc_pkg::offs_t offs);
    return {16'h0, soc_pkg::REGION_NATV, offs};
  endfunction

  function automatic soc_pkg::addr_t apb_addr(input soc_pkg::offs_t offs);
    return {16'h0, soc_pkg::REGION_APB, offs};
  endfunction

  function automatic logic [PIN_W-1:0] exp_pins();
    return m_pin_sel ? m_apb_out[PIN_W-1:0] : m_nout[PIN_W-1:0];
  endfunction

  function automatic soc_pkg::irq_vec_t exp_irq(input logic tmr);
    soc_pkg::irq_vec_t v;
    v = '0;
    v[soc_pkg::IRQ_TMR] = tmr;
    v[soc_pkg::IRQ_SW] = m_sw_irq;
    v[soc_pkg::IRQ_EXT] = ext_irq;
    return v;
  endfunction

  task automatic check_data(input string name, input soc_pkg::data_t got,
                            input soc_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pins(input string name, input logic [PIN_W-1:0] got,
                            input logic [PIN_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_irq(input string name, input soc_pkg::irq_vec_t got,
                           input soc_pkg::irq_vec_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // runs from a falling edge to the falling edge after the completing edge
  task automatic bus_access(input logic we, input soc_pkg::addr_t addr,
                            input soc_pkg::data_t wdata, output soc_pkg::data_t rdata);
    int unsigned lat;
    int unsigned exp_lat;
    lat = 0;
    exp_lat = (addr[15:12] == soc_pkg::REGION_APB) ? 2 : 1;
    nmi_req.valid = 1'b1;
    nmi_req.we = we;
    nmi_req.addr = addr;
    nmi_req.wdata = wdata;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!nmi_rsp.ready);
    rdata = nmi_rsp.rdata;
    if (lat != exp_lat) begin
      $display("access to %h took %0d cycles instead of %0d", addr, lat, exp_lat);
      errors++;
    end
    @(negedge clk_i);
    nmi_req.valid = 1'b0;
    nmi_req.we = 1'b0;
  endtask

  initial begin
    repeat (N_ACCESS * 200 + 2000) @(posedge clk_i);
    $display("watchdog expired, the bus stopped answering");
    $display("errors: %0d", errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    soc_pkg::data_t   rd;
    soc_pkg::data_t   wd;
    logic [31:0]      r;
    soc_pkg::region_t rg;
    int unsigned      cmp;
    int unsigned      waited;
    seed = 32'h2a78;
    errors = 0;
    nmi_req = '0;
    ext_irq = 1'b0;
    rst_n_i = 1'b0;
    m_nout = '0;
    m_apb_out = '0;
    m_cmp = '0;
    m_pin_sel = 1'b0;
    m_sw_irq = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_pins("pins_o", pins, '0);
    check_irq("irq_o", irq, '0);

    // random register traffic with a latency check on every access
    for (int i = 0; i < N_RAND; i++) begin
      r = next_rand();
      wd = next_rand();
      case (r % 7)
        0: begin
          bus_access(1'b1, natv_addr(soc_pkg::SYS_NOUT), wd, rd);
          m_nout = wd & PIN_MASK;
        end
        1: begin
          bus_access(1'b0, natv_addr(soc_pkg::SYS_NOUT), '0, rd);
          check_data("rdata SYS_NOUT", rd, m_nout);
        end
        2: begin
          bus_access(1'b1, apb_addr(soc_pkg::APB_OUT), wd, rd);
          m_apb_out = wd & PIN_MASK;
        end
        3: begin
          bus_access(1'b0, apb_addr(soc_pkg::APB_OUT), '0, rd);
          check_data("rdata APB_OUT", rd, m_apb_out);
        end
        4: begin
          bus_access(1'b1, apb_addr(soc_pkg::TMR_CMP), wd, rd);
          m_cmp = wd;
        end
        5: begin
          bus_access(1'b0, apb_addr(soc_pkg::TMR_CMP), '0, rd);
          check_data("rdata TMR_CMP", rd, m_cmp);
        end
        default: begin
          rg = r[11:8];
          if (rg < 4'd2) begin
            rg = rg + 4'd2;
          end
          bus_access(1'b0, {wd[31:16], rg, wd[11:0]}, '0, rd);
          check_data("rdata unmapped", rd, '0);
        end
      endcase
      check_pins("pins_o", pins, exp_pins());
    end

    // pin mux under random select
    for (int i = 0; i < N_MUX; i++) begin
      wd = next_rand();
      bus_access(1'b1, natv_addr(soc_pkg::SYS_NOUT), wd, rd);
      m_nout = wd & PIN_MASK;
      wd = next_rand();
      bus_access(1'b1, apb_addr(soc_pkg::APB_OUT), wd, rd);
      m_apb_out = wd & PIN_MASK;
      wd = next_rand();
      bus_access(1'b1, natv_addr(soc_pkg::SYS_CTRL), wd, rd);
      m_pin_sel = wd[0];
      check_pins("pins_o", pins, exp_pins());
      bus_access(1'b0, natv_addr(soc_pkg::SYS_CTRL), '0, rd);
      check_data("rdata SYS_CTRL", rd, {31'b0, m_pin_sel});
    end

    // software and external interrupt lines
    for (int i = 0; i < N_IRQ; i++) begin
      r = next_rand();
      wd = next_rand();
      ext_irq = r[3];
      bus_access(1'b1, natv_addr(soc_pkg::SYS_SWIRQ), wd, rd);
      m_sw_irq = wd[0];
      check_irq("irq_o", irq, exp_irq(1'b0));
    end

    // timer compare interrupt
    cmp = 1 + next_rand() % 50;
    bus_access(1'b1, apb_addr(soc_pkg::TMR_CMP), cmp, rd);
    m_cmp = cmp;
    bus_access(1'b1, apb_addr(soc_pkg::TMR_CTRL), 32'h1, rd);
    waited = 0;
    while (!irq[soc_pkg::IRQ_TMR] && waited < cmp + 5) begin
      @(negedge clk_i);
      waited++;
    end
    if (!irq[soc_pkg::IRQ_TMR]) begin
      $display("timer interrupt did not rise within %0d cycles of enable", waited);
      errors++;
    end
    check_irq("irq_o", irq, exp_irq(1'b1));
    bus_access(1'b0, apb_addr(soc_pkg::TMR_CTRL), '0, rd);
    check_data("rdata TMR_CTRL", rd, 32'h3);
    // stop the count before clearing pending
    bus_access(1'b1, apb_addr(soc_pkg::TMR_CTRL), 32'h0, rd);
    bus_access(1'b1, apb_addr(soc_pkg::TMR_CTRL), 32'h2, rd);
    check_irq("irq_o", irq, exp_irq(1'b0));
    bus_access(1'b0, apb_addr(soc_pkg::TMR_CTRL), '0, rd);
    check_data("rdata TMR_CTRL", rd, 32'h0);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/soc_pkg.sv
logic/nmi_bus.sv
logic/sysctrl_regs.sv
logic/nmi_apb_bridge.sv
logic/apb_tmr_gpio.sv
logic/mini_soc.sv
test/tb_mini_soc.sv

// ==== run.sh ====
#!/bin/sh
# build the mini_soc testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir run.log
verilator --binary --timing --assert --top-module tb_mini_soc -f sources.f > run.log 2>&1 \
  && ./obj_dir/Vtb_mini_soc >> run.log 2>&1
grep -q "^Test passed$" run.log && echo "PASS" || { echo "FAIL, see run.log"; exit 1; }
